//--- all.f
+incdir+verif
hdl/evict_pkg.sv
hdl/sync_fifo.sv
hdl/evict_aw_queue.sv
hdl/evict_w_queue.sv
hdl/evict_csr.sv
hdl/evict_top.sv
verif/evict_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := evict_tb
FLIST      := all.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/evict_tb_mem.svh
int aw_cnt = 0;
int w_cnt = 0;
int beat_cnt = 0;
int b_sent = 0;
int b_cnt = 0;
evict_pkg::addr_t addr_seen [NROWS];
evict_pkg::axi_id_t id_seen [NROWS];

// beat b of the line built from seed
function automatic evict_pkg::beat_t beat_pattern(input logic [31:0] seed, input int b);
	return {seed + 32'(b), ~seed ^ {4{8'(b)}}};
endfunction

function automatic evict_pkg::line_t make_line(input logic [31:0] seed);
	evict_pkg::line_t line;
	for (int b = 0; b < evict_pkg::BEATS; b++)
		line[b * evict_pkg::DATA_W +: evict_pkg::DATA_W] = beat_pattern(seed, b);
	return line;
endfunction

function automatic logic ready_draw(input logic [7:0] stall);
	logic [31:0] r;
	r = $random(seed);
	return (r[30:0] % 31'd100) >= 31'(stall);
endfunction

function automatic int row_of(input int n);
	return (n < NROWS) ? n : NROWS - 1;
endfunction

// ****************************************************************************
// AXI4 write slave
// ****************************************************************************
task automatic memory_model();
	evict_pkg::aw_req_t aw_prev;
	evict_pkg::w_beat_t w_prev;
	logic aw_stalled;
	logic w_stalled;
	aw_stalled = 1'b0;
	w_stalled = 1'b0;
	forever begin
		@(posedge clk);
		if (!bus_open && (awvalid_o || wvalid_o))
			expect_true(1'b0, "burst started while enable was clear");
		if (aw_stalled) begin
			check_eq("awvalid_o (held)", 64'd1, 64'(awvalid_o));
			check_eq("aw_o (held)", 64'(aw_prev), 64'(aw_o));
		end
		if (w_stalled) begin
			check_eq("wvalid_o (held)", 64'd1, 64'(wvalid_o));
			check_eq("w_o.data (held)", w_prev.data, w_o.data);
			check_eq("w_o.last (held)", 64'(w_prev.last), 64'(w_o.last));
		end
		if (awvalid_o && awready_i) begin
			expect_true(aw_cnt < NROWS, "AW burst beyond the end of the table");
			if (aw_cnt < NROWS) begin
				check_eq("aw_o.addr", 64'(rows[aw_cnt].addr), 64'(aw_o.addr));
				check_eq("aw_o.id", 64'(AWID), 64'(aw_o.id));
				check_eq("aw_o.len", 64'd7, 64'(aw_o.len));
				check_eq("aw_o.size", 64'd3, 64'(aw_o.size));
				addr_seen[aw_cnt] = aw_o.addr;
				id_seen[aw_cnt] = aw_o.id;
				aw_cnt++;
			end
		end
		if (wvalid_o && wready_i) begin
			expect_true(w_cnt < NROWS, "W beat beyond the end of the table");
			if (w_cnt < NROWS) begin
				check_eq("w_o.data", beat_pattern(rows[w_cnt].seed, beat_cnt), w_o.data);
				check_eq("w_o.last", 64'(beat_cnt == 7), 64'(w_o.last));
				check_eq("w_o.strb", 64'hff, 64'(w_o.strb));
				if (beat_cnt == 7) begin
					beat_cnt = 0;
					w_cnt++;
				end else begin
					beat_cnt++;
				end
			end
		end
		if (bvalid_i && bready_o)
			b_cnt++;
		// one B per burst once both its AW and its last beat are in
		if ((!bvalid_i || bready_o) && b_sent < aw_cnt && b_sent < w_cnt) begin
			b_i <= '{id_seen[b_sent],
				addr_seen[b_sent][12] ? evict_pkg::RESP_SLVERR : evict_pkg::RESP_OKAY};
			bvalid_i <= 1'b1;
			b_sent++;
		end else if (bvalid_i && bready_o) begin
			bvalid_i <= 1'b0;
		end
		aw_stalled = awvalid_o && !awready_i;
		w_stalled = wvalid_o && !wready_i;
		aw_prev = aw_o;
		w_prev = w_o;
		awready_i <= ready_draw(rows[row_of(aw_cnt)].stall);
		wready_i <= ready_draw(rows[row_of(w_cnt)].stall);
	end
endtask

// ****************************************************************************
// AXI4-Lite master
// ****************************************************************************
task automatic lite_write(input logic [31:0] addr, input logic [31:0] data,
		output evict_pkg::resp_t resp);
	@(posedge clk);
	s_aw_i.addr <= addr;
	s_w_i.data <= data;
	s_w_i.strb <= 4'hf;
	s_awvalid_i <= 1'b1;
	s_wvalid_i <= 1'b1;
	@(posedge clk);
	while (!(s_awready_o && s_wready_o))
		@(posedge clk);
	s_awvalid_i <= 1'b0;
	s_wvalid_i <= 1'b0;
	s_bready_i <= 1'b1;
	@(posedge clk);
	while (!s_bvalid_o)
		@(posedge clk);
	resp = s_bresp_o;
	s_bready_i <= 1'b0;
endtask

task automatic lite_read(input logic [31:0] addr, output logic [31:0] data,
		output evict_pkg::resp_t resp);
	@(posedge clk);
	s_araddr_i <= addr;
	s_arvalid_i <= 1'b1;
	@(posedge clk);
	while (!s_arready_o)
		@(posedge clk);
	s_arvalid_i <= 1'b0;
	s_rready_i <= 1'b1;
	@(posedge clk);
	while (!s_rvalid_o)
		@(posedge clk);
	data = s_r_o.data;
	resp = s_r_o.resp;
	s_rready_i <= 1'b0;
endtask

//--- verif/evict_tb.sv
`timescale 1ns/1ps

module evict_tb;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] seed;	// line pattern
		logic [7:0] stall;	// percent of cycles without ready
		evict_pkg::resp_t resp;
	} row_t;

	localparam int NROWS = 6;
	localparam int GROUP = evict_pkg::Q_DEPTH - 1;
	localparam evict_pkg::axi_id_t AWID = 4'h5;

	row_t rows [NROWS] = '{
		'{32'h8000_0040, 32'h1111_0001, 8'd0, evict_pkg::RESP_OKAY},
		'{32'h8000_1080, 32'h2222_0002, 8'd0, evict_pkg::RESP_SLVERR},
		'{32'h8000_20C0, 32'h3333_0003, 8'd0, evict_pkg::RESP_OKAY},
		'{32'h8000_3100, 32'h4444_0004, 8'd40, evict_pkg::RESP_SLVERR},
		'{32'h9000_0140, 32'h5555_0005, 8'd40, evict_pkg::RESP_OKAY},
		'{32'h9000_5180, 32'h6666_0006, 8'd40, evict_pkg::RESP_SLVERR}
	};

	logic clk;
	logic rst_n;
	logic evict_wr_i;
	evict_pkg::addr_t evict_addr_i;
	evict_pkg::line_t evict_line_i;
	logic evict_afull_o;
	evict_pkg::aw_req_t aw_o;
	logic awvalid_o;
	logic awready_i;
	evict_pkg::w_beat_t w_o;
	logic wvalid_o;
	logic wready_i;
	evict_pkg::b_rsp_t b_i;
	logic bvalid_i;
	logic bready_o;
	evict_pkg::lite_aw_t s_aw_i;
	logic s_awvalid_i;
	logic s_awready_o;
	evict_pkg::lite_w_t s_w_i;
	logic s_wvalid_i;
	logic s_wready_o;
	evict_pkg::resp_t s_bresp_o;
	logic s_bvalid_o;
	logic s_bready_i;
	logic [31:0] s_araddr_i;
	logic s_arvalid_i;
	logic s_arready_o;
	evict_pkg::lite_r_t s_r_o;
	logic s_rvalid_o;
	logic s_rready_i;

	integer seed = 61;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	logic bus_open = 1'b0;	// bursts allowed

	evict_top u_evict_top (.*);

	`include "evict_tb_mem.svh"

	always #5 clk = ~clk;

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			$display("error %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		$display("test %-12s %s (%0d errors)", name, (errors == err0) ? "ok" : "FAIL",
			errors - err0);
	endtask

	// ************************************************************************
	// watchdog
	// ************************************************************************
	initial begin
		repeat (NROWS * 200 + 1000) @(posedge clk);
		$display("timeout, run still busy after %0d cycles", NROWS * 200 + 1000);
		$display("sim failed");
		$finish;
	end

	initial memory_model();

	// ************************************************************************
	// test sequence
	// ************************************************************************
	initial begin
		row_t row;
		evict_pkg::resp_t resp;
		logic [31:0] data;
		int err0;
		int n_okay;
		clk = 1'b0;
		rst_n <= 1'b0;
		evict_wr_i <= 1'b0;
		evict_addr_i <= '0;
		evict_line_i <= '0;
		awready_i <= 1'b0;
		wready_i <= 1'b0;
		b_i <= '0;
		bvalid_i <= 1'b0;
		s_aw_i <= '0;
		s_awvalid_i <= 1'b0;
		s_w_i <= '0;
		s_wvalid_i <= 1'b0;
		s_bready_i <= 1'b0;
		s_araddr_i <= '0;
		s_arvalid_i <= 1'b0;
		s_rready_i <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		err0 = errors;
		@(posedge clk);
		check_eq("awvalid_o", 64'd0, 64'(awvalid_o));
		check_eq("wvalid_o", 64'd0, 64'(wvalid_o));
		check_eq("bready_o", 64'd0, 64'(bready_o));
		check_eq("evict_afull_o", 64'd0, 64'(evict_afull_o));
		check_eq("s_awready_o", 64'd0, 64'(s_awready_o));
		check_eq("s_wready_o", 64'd0, 64'(s_wready_o));
		check_eq("s_arready_o", 64'd0, 64'(s_arready_o));
		check_eq("s_bvalid_o", 64'd0, 64'(s_bvalid_o));
		check_eq("s_rvalid_o", 64'd0, 64'(s_rvalid_o));
		lite_read(32'(evict_pkg::REG_CTRL), data, resp);
		check_eq("ctrl", 64'd0, 64'(data));
		end_test("reset", err0);

		err0 = errors;
		lite_write(32'(evict_pkg::REG_CTRL), {24'h0, AWID, 4'h1}, resp);
		check_eq("s_bresp_o", 64'(evict_pkg::RESP_OKAY), 64'(resp));
		lite_read(32'(evict_pkg::REG_CTRL), data, resp);
		check_eq("ctrl", 64'h51, 64'(data));
		lite_write(32'h10, 32'hdead_beef, resp);
		check_eq("s_bresp_o", 64'(evict_pkg::RESP_SLVERR), 64'(resp));
		lite_read(32'h10, data, resp);
		check_eq("s_r_o.resp", 64'(evict_pkg::RESP_SLVERR), 64'(resp));
		check_eq("s_r_o.data", 64'd0, 64'(data));
		lite_write(32'(evict_pkg::REG_CTRL), {24'h0, AWID, 4'h0}, resp);	// enable off
		end_test("registers", err0);

		for (int g = 0; g < NROWS / GROUP; g++) begin
			err0 = errors;
			@(posedge clk);
			check_eq("evict_afull_o", 64'd0, 64'(evict_afull_o));
			for (int k = 0; k < GROUP; k++) begin
				row = rows[g * GROUP + k];
				evict_wr_i <= 1'b1;
				evict_addr_i <= row.addr;
				evict_line_i <= make_line(row.seed);
				@(posedge clk);
			end
			evict_wr_i <= 1'b0;
			repeat (2) @(posedge clk);
			check_eq("evict_afull_o", 64'd1, 64'(evict_afull_o));
			lite_read(32'(evict_pkg::REG_STATUS), data, resp);
			check_eq("status", 64'(GROUP), 64'(data));
			bus_open = 1'b1;
			lite_write(32'(evict_pkg::REG_CTRL), {24'h0, AWID, 4'h1}, resp);
			while (b_cnt < (g + 1) * GROUP)
				@(posedge clk);
			lite_write(32'(evict_pkg::REG_CTRL), {24'h0, AWID, 4'h0}, resp);
			bus_open = 1'b0;
			end_test((rows[g * GROUP].stall == 0) ? "drain" : "drain_stall", err0);
		end

		err0 = errors;
		n_okay = 0;
		for (int i = 0; i < NROWS; i++)
			if (rows[i].resp == evict_pkg::RESP_OKAY)
				n_okay++;
		lite_read(32'(evict_pkg::REG_WB_CNT), data, resp);
		check_eq("wb_cnt", 64'(n_okay), 64'(data));
		lite_read(32'(evict_pkg::REG_ERR_CNT), data, resp);
		check_eq("err_cnt", 64'(NROWS - n_okay), 64'(data));
		lite_write(32'(evict_pkg::REG_WB_CNT), 32'h0, resp);
		lite_read(32'(evict_pkg::REG_WB_CNT), data, resp);
		check_eq("wb_cnt", 64'd0, 64'(data));
		lite_read(32'(evict_pkg::REG_ERR_CNT), data, resp);
		check_eq("err_cnt", 64'd0, 64'(data));
		end_test("counters", err0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- hdl/evict_top.sv
`timescale 1ns/1ps

module evict_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            evict_wr_i,
	input  evict_pkg::addr_t                evict_addr_i,
	input  evict_pkg::line_t                evict_line_i,
	output logic                            evict_afull_o,
	output evict_pkg::aw_req_t              aw_o,
	output logic                            awvalid_o,
	input  logic                            awready_i,
	output evict_pkg::w_beat_t              w_o,
	output logic                            wvalid_o,
	input  logic                            wready_i,
	input  evict_pkg::b_rsp_t               b_i,
	input  logic                            bvalid_i,
	output logic                            bready_o,
	input  evict_pkg::lite_aw_t             s_aw_i,
	input  logic                            s_awvalid_i,
	output logic                            s_awready_o,
	input  evict_pkg::lite_w_t              s_w_i,
	input  logic                            s_wvalid_i,
	output logic                            s_wready_o,
	output evict_pkg::resp_t                s_bresp_o,
	output logic                            s_bvalid_o,
	input  logic                            s_bready_i,
	input  logic [evict_pkg::LITE_W-1:0]    s_araddr_i,
	input  logic                            s_arvalid_i,
	output logic                            s_arready_o,
	output evict_pkg::lite_r_t              s_r_o,
	output logic                            s_rvalid_o,
	input  logic                            s_rready_i
);

	evict_pkg::evict_cfg_t cfg;
	evict_pkg::level_t w_level;

	evict_aw_queue u_aw_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_i     (cfg),
		.wr_i      (evict_wr_i),
		.addr_i    (evict_addr_i),
		.aw_o      (aw_o),
		.awvalid_o (awvalid_o),
		.awready_i (awready_i)
	);

	evict_w_queue u_w_queue (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_i    (cfg),
		.wr_i     (evict_wr_i),
		.line_i   (evict_line_i),
		.w_o      (w_o),
		.wvalid_o (wvalid_o),
		.wready_i (wready_i),
		.afull_o  (evict_afull_o),	// w level never below aw level
		.level_o  (w_level)
	);

	evict_csr u_csr (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_aw_i      (s_aw_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_w_i       (s_w_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_r_o       (s_r_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.b_i         (b_i),
		.bvalid_i    (bvalid_i),
		.bready_o    (bready_o),
		.w_level_i   (w_level),
		.cfg_o       (cfg)
	);

endmodule

//--- hdl/evict_csr.sv
`timescale 1ns/1ps

module evict_csr (
	input  logic                            clk,
	input  logic                            rst_n,
	input  evict_pkg::lite_aw_t             s_aw_i,
	input  logic                            s_awvalid_i,
	output logic                            s_awready_o,
	input  evict_pkg::lite_w_t              s_w_i,
	input  logic                            s_wvalid_i,
	output logic                            s_wready_o,
	output evict_pkg::resp_t                s_bresp_o,
	output logic                            s_bvalid_o,
	input  logic                            s_bready_i,
	input  logic [evict_pkg::LITE_W-1:0]    s_araddr_i,
	input  logic                            s_arvalid_i,
	output logic                            s_arready_o,
	output evict_pkg::lite_r_t              s_r_o,
	output logic                            s_rvalid_o,
	input  logic                            s_rready_i,
	input  evict_pkg::b_rsp_t               b_i,
	input  logic                            bvalid_i,
	output logic                            bready_o,
	input  evict_pkg::level_t               w_level_i,
	output evict_pkg::evict_cfg_t           cfg_o
);

	evict_pkg::lite_state_t state_q;
	evict_pkg::cnt_t wb_cnt_q;
	evict_pkg::cnt_t err_cnt_q;
	logic [evict_pkg::LITE_W-1:0] rd_data;
	evict_pkg::resp_t rd_resp;
	logic [7:0] wr_off;
	logic [7:0] rd_off;
	logic wr_acc_q;
	logic rd_acc_q;
	logic wr_hit;
	logic cnt_clr;
	logic b_fire;

	assign wr_off = s_aw_i.addr[7:0];
	assign rd_off = s_araddr_i[7:0];

	assign s_awready_o = wr_acc_q;	// aw and w taken together
	assign s_wready_o = wr_acc_q;
	assign s_arready_o = rd_acc_q;
	assign s_bvalid_o = (state_q == evict_pkg::LITE_WRESP);
	assign s_rvalid_o = (state_q == evict_pkg::LITE_RDATA);

	assign bready_o = cfg_o.enable;
	assign b_fire = bvalid_i && bready_o;

	assign wr_hit = (wr_off == evict_pkg::REG_CTRL) || (wr_off == evict_pkg::REG_STATUS) ||
		(wr_off == evict_pkg::REG_WB_CNT) || (wr_off == evict_pkg::REG_ERR_CNT);
	assign cnt_clr = wr_acc_q && (wr_off == evict_pkg::REG_WB_CNT);

	// ***************************************************************************
	// register bus handshake
	// ***************************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= evict_pkg::LITE_IDLE;
			wr_acc_q <= 1'b0;
			rd_acc_q <= 1'b0;
			cfg_o <= '0;
		end else begin
			wr_acc_q <= 1'b0;
			rd_acc_q <= 1'b0;
			case (state_q)
				evict_pkg::LITE_IDLE: begin
					if (wr_acc_q) begin
						state_q <= evict_pkg::LITE_WRESP;
						if (wr_off == evict_pkg::REG_CTRL && s_w_i.strb[0]) begin
							cfg_o.enable <= s_w_i.data[0];
							cfg_o.awid <= s_w_i.data[7:4];
						end
					end else if (rd_acc_q) begin
						state_q <= evict_pkg::LITE_RDATA;
					end else if (s_awvalid_i && s_wvalid_i) begin
						wr_acc_q <= 1'b1;	// writes win over reads
					end else if (s_arvalid_i) begin
						rd_acc_q <= 1'b1;
					end
				end
				evict_pkg::LITE_WRESP: begin
					if (s_bready_i)
						state_q <= evict_pkg::LITE_IDLE;
				end
				evict_pkg::LITE_RDATA: begin
					if (s_rready_i)
						state_q <= evict_pkg::LITE_IDLE;
				end
				default: state_q <= evict_pkg::LITE_IDLE;
			endcase
		end
	end

	always_comb begin
		rd_data = '0;
		rd_resp = evict_pkg::RESP_OKAY;
		case (rd_off)
			evict_pkg::REG_CTRL: begin
				rd_data[0] = cfg_o.enable;
				rd_data[7:4] = cfg_o.awid;
			end
			evict_pkg::REG_STATUS: rd_data[$bits(evict_pkg::level_t)-1:0] = w_level_i;
			evict_pkg::REG_WB_CNT: rd_data[15:0] = wb_cnt_q;
			evict_pkg::REG_ERR_CNT: rd_data[15:0] = err_cnt_q;
			default: rd_resp = evict_pkg::RESP_SLVERR;	// unmapped reads as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (wr_acc_q)
			s_bresp_o <= wr_hit ? evict_pkg::RESP_OKAY : evict_pkg::RESP_SLVERR;
		if (rd_acc_q) begin
			s_r_o.data <= rd_data;
			s_r_o.resp <= rd_resp;
		end
	end

	// ***************************************************************************
	// write response counters
	// ***************************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_cnt_q <= '0;
			err_cnt_q <= '0;
		end else if (cnt_clr) begin
			wb_cnt_q <= '0;
			err_cnt_q <= '0;
		end else if (b_fire) begin
			if (b_i.resp == evict_pkg::RESP_OKAY)
				wb_cnt_q <= wb_cnt_q + 1'b1;
			else
				err_cnt_q <= err_cnt_q + 1'b1;
		end
	end

endmodule

//--- hdl/evict_w_queue.sv
`timescale 1ns/1ps

module evict_w_queue (
	input  logic                     clk,
	input  logic                     rst_n,
	input  evict_pkg::evict_cfg_t    cfg_i,
	input  logic                     wr_i,
	input  evict_pkg::line_t         line_i,
	output evict_pkg::w_beat_t       w_o,
	output logic                     wvalid_o,
	input  logic                     wready_i,
	output logic                     afull_o,
	output evict_pkg::level_t        level_o
);

	evict_pkg::w_state_t state_q;
	evict_pkg::line_t fifo_line;
	evict_pkg::line_t line_q;
	evict_pkg::level_t fifo_level;
	logic [$clog2(evict_pkg::BEATS)-1:0] beat_q;
	logic fifo_empty;
	logic fifo_afull;
	logic fifo_rd;
	logic load_q;
	logic busy;
	logic beat_fire;
	logic last;

	sync_fifo #(
		.WIDTH (evict_pkg::LINE_W),
		.DEPTH (evict_pkg::Q_DEPTH)
	) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (wr_i),
		.wr_data_i (line_i),
		.rd_en_i   (fifo_rd),
		.rd_data_o (fifo_line),
		.empty_o   (fifo_empty),
		.level_o   (fifo_level),
		.afull_o   (fifo_afull)
	);

	assign fifo_rd = (state_q == evict_pkg::W_IDLE) && !load_q && cfg_i.enable && !fifo_empty;
	assign wvalid_o = (state_q == evict_pkg::W_SEND);
	assign beat_fire = wvalid_o && wready_i;
	assign last = &beat_q;	// BEATS is a power of two

	// head line still counts until its last beat is taken
	assign busy = load_q || wvalid_o;
	assign level_o = fifo_level + evict_pkg::level_t'(busy);
	assign afull_o = fifo_afull ||
		(busy && fifo_level >= evict_pkg::level_t'(evict_pkg::Q_DEPTH - 2));

	assign w_o.data = line_q[evict_pkg::DATA_W-1:0];	// low slice first
	assign w_o.strb = '1;
	assign w_o.last = last;

	// ***************************************************************************
	// burst control
	// ***************************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= evict_pkg::W_IDLE;
			load_q <= 1'b0;
			beat_q <= '0;
		end else begin
			load_q <= fifo_rd;
			case (state_q)
				evict_pkg::W_IDLE: begin
					if (load_q) begin
						state_q <= evict_pkg::W_SEND;
						beat_q <= '0;
					end
				end
				evict_pkg::W_SEND: begin
					if (beat_fire) begin
						beat_q <= beat_q + 1'b1;
						if (last)
							state_q <= evict_pkg::W_IDLE;
					end
				end
				default: state_q <= evict_pkg::W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_q)
			line_q <= fifo_line;
		else if (beat_fire)
			line_q <= line_q >> evict_pkg::DATA_W;	// next beat down
	end

endmodule

//--- hdl/evict_aw_queue.sv
`timescale 1ns/1ps

module evict_aw_queue (
	input  logic                     clk,
	input  logic                     rst_n,
	input  evict_pkg::evict_cfg_t    cfg_i,
	input  logic                     wr_i,
	input  evict_pkg::addr_t         addr_i,
	output evict_pkg::aw_req_t       aw_o,
	output logic                     awvalid_o,
	input  logic                     awready_i
);

	evict_pkg::aw_state_t state_q;
	evict_pkg::aw_state_t state_n;
	evict_pkg::addr_t fifo_addr;
	evict_pkg::aw_req_t aw_q;
	logic fifo_empty;
	logic fifo_rd;

	sync_fifo #(
		.WIDTH (evict_pkg::ADDR_W),
		.DEPTH (evict_pkg::Q_DEPTH)
	) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (wr_i),
		.wr_data_i (addr_i),
		.rd_en_i   (fifo_rd),
		.rd_data_o (fifo_addr),
		.empty_o   (fifo_empty),
		.level_o   (),
		.afull_o   ()
	);

	// ***************************************************************************
	// pop, load, send
	// ***************************************************************************
	always_comb begin
		state_n = state_q;
		fifo_rd = 1'b0;
		case (state_q)
			evict_pkg::AW_IDLE: begin
				if (cfg_i.enable && !fifo_empty) begin
					fifo_rd = 1'b1;
					state_n = evict_pkg::AW_LOAD;
				end
			end
			evict_pkg::AW_LOAD: state_n = evict_pkg::AW_SEND;	// fifo data valid now
			evict_pkg::AW_SEND: begin
				if (awready_i)
					state_n = evict_pkg::AW_IDLE;
			end
			default: state_n = evict_pkg::AW_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state_q <= evict_pkg::AW_IDLE;
		else
			state_q <= state_n;
	end

	always_ff @(posedge clk) begin
		if (state_q == evict_pkg::AW_LOAD) begin
			aw_q.id <= cfg_i.awid;
			aw_q.addr <= fifo_addr;
			aw_q.len <= evict_pkg::AXI_LEN;
			aw_q.size <= evict_pkg::AXI_SIZE;
		end
	end

	assign aw_o = aw_q;
	assign awvalid_o = (state_q == evict_pkg::AW_SEND);

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wr_en_i,
	input  logic [WIDTH-1:0]     wr_data_i,
	input  logic                 rd_en_i,
	output logic [WIDTH-1:0]     rd_data_o,
	output logic                 empty_o,
	output evict_pkg::level_t    level_o,
	output logic                 afull_o
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(DEPTH)-1:0] rd_ptr_q;
	evict_pkg::level_t level_q;
	logic do_wr;
	logic do_rd;

	assign empty_o = (level_q == '0);
	assign level_o = level_q;
	assign afull_o = (level_q >= evict_pkg::level_t'(DEPTH - 1));

	assign do_wr = wr_en_i && (level_q != evict_pkg::level_t'(DEPTH));	// drop on full
	assign do_rd = rd_en_i && !empty_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q <= '0;
		end else begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;	// wraps, DEPTH is 2^n
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_wr, do_rd})
				2'b10: level_q <= level_q + 1'b1;
				2'b01: level_q <= level_q - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr_q] <= wr_data_i;
		if (do_rd)
			rd_data_o <= mem[rd_ptr_q];	// valid the cycle after rd_en_i
	end

endmodule

//--- hdl/evict_pkg.sv
package evict_pkg;

	// ***************************************************************************
	// widths and bus constants
	// ***************************************************************************
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int LINE_W = 512;
	localparam int BEATS = 8;
	localparam int ID_W = 4;
	localparam int Q_DEPTH = 4;
	localparam int LITE_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int LITE_STRB_W = LITE_W / 8;

	localparam logic [7:0] AXI_LEN = 8'd7;	// beats - 1
	localparam logic [2:0] AXI_SIZE = 3'd3;	// 8 bytes per beat

	localparam logic [7:0] REG_CTRL = 8'h00;
	localparam logic [7:0] REG_STATUS = 8'h04;
	localparam logic [7:0] REG_WB_CNT = 8'h08;
	localparam logic [7:0] REG_ERR_CNT = 8'h0C;

	// ***************************************************************************
	// types
	// ***************************************************************************
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] beat_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [ID_W-1:0] axi_id_t;
	typedef logic [$clog2(Q_DEPTH+1)-1:0] level_t;	// 0..Q_DEPTH
	typedef logic [1:0] resp_t;
	typedef logic [15:0] cnt_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	typedef struct packed {
		axi_id_t id;
		addr_t addr;
		logic [7:0] len;
		logic [2:0] size;
	} aw_req_t;

	typedef struct packed {
		beat_t data;
		logic [STRB_W-1:0] strb;
		logic last;
	} w_beat_t;

	typedef struct packed {
		axi_id_t id;
		resp_t resp;
	} b_rsp_t;

	typedef struct packed {
		logic enable;
		axi_id_t awid;
	} evict_cfg_t;

	typedef struct packed {
		logic [LITE_W-1:0] addr;
	} lite_aw_t;

	typedef struct packed {
		logic [LITE_W-1:0] data;
		logic [LITE_STRB_W-1:0] strb;
	} lite_w_t;

	typedef struct packed {
		logic [LITE_W-1:0] data;
		resp_t resp;
	} lite_r_t;

	typedef enum logic [1:0] {
		AW_IDLE,
		AW_LOAD,
		AW_SEND
	} aw_state_t;

	typedef enum logic {
		W_IDLE,
		W_SEND
	} w_state_t;

	typedef enum logic [1:0] {
		LITE_IDLE,
		LITE_WRESP,
		LITE_RDATA
	} lite_state_t;

endpackage
